// ==== shift_pkg.sv ====
package shift_pkg;

////////////////////////////////////////////////////////////////////////////
// Data widths.
////////////////////////////////////////////////////////////////////////////

// One data word.
localparam int WORD_W = 32;

// Issue operand field. Bit 32 marks an immediate.
localparam int SRC_W = 33;

// Position of the immediate flag.
localparam int IMMED_EN = 32;

// Used part of the shift length operand.
localparam int AMT_W = 8;

////////////////////////////////////////////////////////////////////////////
// Registers and conditions.
////////////////////////////////////////////////////////////////////////////

// Physical index of the program counter.
localparam int PHY_PC = 15;

// Condition code width.
localparam int CC_W = 4;

// Condition "never". A killed instruction carries it.
localparam logic [CC_W-1:0] CC_NV = 4'd15;

// Clears the two low bits on an aligned PC read.
localparam logic [WORD_W-1:0] PC_ALIGN_MASK = 32'hFFFF_FFFC;

////////////////////////////////////////////////////////////////////////////
// Shift operations.
////////////////////////////////////////////////////////////////////////////

// Codes 5 to 7 are illegal.
typedef enum logic [2:0]
{
        SH_LSL = 3'd0,
        SH_LSR = 3'd1,
        SH_ASR = 3'd2,
        SH_ROR = 3'd3,
        SH_RRX = 3'd4
} shift_op_t;

endpackage

// ==== operand_resolver.sv ====
`timescale 1ns/1ns

module operand_resolver import shift_pkg::*;
#(
        parameter int PHY_REGS = 46,
        localparam int IDX_W = $clog2(PHY_REGS)
)
(
        // Operand field and the value read at issue.
        input  logic [SRC_W-1:0]  i_index,
        input  logic [WORD_W-1:0] i_value,

        // Destination held in the stage register.
        input  logic [IDX_W-1:0]  i_stage_dest_index,

        // Unregistered ALU result.
        input  logic [WORD_W-1:0] i_alu_value,
        input  logic              i_alu_valid,

        // Program counter view.
        input  logic [WORD_W-1:0] i_pc_plus_8,
        input  logic              i_align32,

        output logic [WORD_W-1:0] o_value
);

// Highest priority first.
always_comb
begin
        if (i_index[IMMED_EN])
        begin
                // Immediate in the low word.
                o_value = i_index[WORD_W-1:0];
        end
        else if (i_index[WORD_W-1:0] == WORD_W'(PHY_PC))
        begin
                // PC read, word aligned on request.
                o_value = i_align32 ? (i_pc_plus_8 & PC_ALIGN_MASK) : i_pc_plus_8;
        end
        else if ((i_index[IDX_W-1:0] == i_stage_dest_index) && i_alu_valid)
        begin
                // Instruction ahead writes this register. Take its result.
                o_value = i_alu_value;
        end
        else
        begin
                // Register file value is current.
                o_value = i_value;
        end
end

endmodule

// ==== barrel_shifter.sv ====
`timescale 1ns/1ns

module barrel_shifter import shift_pkg::*;
(
        // Used only by the assertion.
        input  logic              i_clk,
        input  logic              i_check_en,

        input  logic [WORD_W-1:0] i_source,
        input  logic [AMT_W-1:0]  i_amount,
        input  shift_op_t         i_shift_type,
        input  logic              i_carry,

        output logic [WORD_W-1:0] o_result,
        output logic              o_carry
);

localparam int ROT_W = $clog2(WORD_W);

////////////////////////////////////////////////////////////////////////////
// Shift datapath.
////////////////////////////////////////////////////////////////////////////

// One extra bit holds the last bit shifted out.
logic [WORD_W:0]       wide;

// Source twice over, for rotates.
logic [2*WORD_W-1:0]   rot_wide;

// Rotate amount modulo the word width.
logic [ROT_W-1:0]      rot_amount;

// ASR saturates at a full word.
logic [AMT_W-1:0]      asr_amount;

always_comb
begin
        rot_amount = i_amount[ROT_W-1:0];
        asr_amount = (i_amount > AMT_W'(WORD_W)) ? AMT_W'(WORD_W) : i_amount;
        wide       = '0;
        rot_wide   = {i_source, i_source} >> rot_amount;

        // Zero amount passes source and carry.
        o_result   = i_source;
        o_carry    = i_carry;

        case (i_shift_type)
        SH_LSL:
        begin
                // Carry lands above bit 31. Beyond 32 everything is gone.
                if (i_amount != '0)
                begin
                        wide     = {1'b0, i_source} << i_amount;
                        o_result = wide[WORD_W-1:0];
                        o_carry  = wide[WORD_W];
                end
        end
        SH_LSR:
        begin
                // Carry lands below bit 0.
                if (i_amount != '0)
                begin
                        wide     = {i_source, 1'b0} >> i_amount;
                        o_result = wide[WORD_W:1];
                        o_carry  = wide[0];
                end
        end
        SH_ASR:
        begin
                // Sign fill. 32 and above give all sign bits.
                if (i_amount != '0)
                begin
                        wide     = $signed({i_source, 1'b0}) >>> asr_amount;
                        o_result = wide[WORD_W:1];
                        o_carry  = wide[0];
                end
        end
        SH_ROR:
        begin
                // Carry is the new bit 31, also for multiples of 32.
                if (i_amount != '0)
                begin
                        o_result = rot_wide[WORD_W-1:0];
                        o_carry  = rot_wide[WORD_W-1];
                end
        end
        SH_RRX:
        begin
                // Rotate through carry by one.
                o_result = {i_carry, i_source[WORD_W-1:1]};
                o_carry  = i_source[0];
        end
        default:
        begin
                // Illegal code. Pass through.
                o_result = i_source;
                o_carry  = i_carry;
        end
        endcase
end

////////////////////////////////////////////////////////////////////////////
// Checks.
////////////////////////////////////////////////////////////////////////////

// Issue never sends an illegal code to a live shift.
a_legal_shift_type: assert property (
        @(posedge i_clk)
        i_check_en |-> (i_shift_type inside {SH_LSL, SH_LSR, SH_ASR, SH_ROR, SH_RRX})
) else $error("illegal shift type %0d with shifter enabled", i_shift_type);

endmodule

// ==== shift_stage_regs.sv ====
`timescale 1ns/1ns

module shift_stage_regs import shift_pkg::*;
#(
        parameter int PHY_REGS = 46,
        parameter int ALU_OPS  = 32,
        localparam int IDX_W   = $clog2(PHY_REGS),
        localparam int OP_W    = $clog2(ALU_OPS)
)
(
        input  logic              i_clk,
        input  logic              i_reset,

        // Pipeline control, highest priority first.
        input  logic              i_clear_from_writeback,
        input  logic              i_data_stall,
        input  logic              i_clear_from_alu,

        // Instruction fields.
        input  logic [CC_W-1:0]   i_condition_code,
        input  logic [IDX_W-1:0]  i_destination_index,
        input  logic [OP_W-1:0]   i_alu_operation,
        input  logic              i_flag_update,

        // Resolved operands.
        input  logic [WORD_W-1:0] i_pc_plus_8,
        input  logic [WORD_W-1:0] i_alu_source_value,
        input  logic [WORD_W-1:0] i_shifted_source_value,
        input  logic [WORD_W-1:0] i_mem_srcdest_value,
        input  logic              i_shift_carry,

        output logic [CC_W-1:0]   o_condition_code_ff,
        output logic [IDX_W-1:0]  o_destination_index_ff,
        output logic [OP_W-1:0]   o_alu_operation_ff,
        output logic              o_flag_update_ff,
        output logic [WORD_W-1:0] o_pc_plus_8_ff,
        output logic [WORD_W-1:0] o_alu_source_value_ff,
        output logic [WORD_W-1:0] o_shifted_source_value_ff,
        output logic [WORD_W-1:0] o_mem_srcdest_value_ff,
        output logic              o_shift_carry_ff
);

////////////////////////////////////////////////////////////////////////////
// Stage flops.
////////////////////////////////////////////////////////////////////////////

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                // Empty stage holds a dead instruction.
                o_condition_code_ff       <= CC_NV;
                o_destination_index_ff    <= '0;
                o_alu_operation_ff        <= '0;
                o_flag_update_ff          <= 1'b0;
                o_pc_plus_8_ff            <= '0;
                o_alu_source_value_ff     <= '0;
                o_shifted_source_value_ff <= '0;
                o_mem_srcdest_value_ff    <= '0;
                o_shift_carry_ff          <= 1'b0;
        end
        else if (i_clear_from_writeback)
        begin
                // Kill the instruction. Fields stay.
                o_condition_code_ff <= CC_NV;
        end
        else if (i_data_stall)
        begin
                // Hold everything.
        end
        else if (i_clear_from_alu)
        begin
                o_condition_code_ff <= CC_NV;
        end
        else
        begin
                o_condition_code_ff       <= i_condition_code;
                o_destination_index_ff    <= i_destination_index;
                o_alu_operation_ff        <= i_alu_operation;
                o_flag_update_ff          <= i_flag_update;
                o_pc_plus_8_ff            <= i_pc_plus_8;
                o_alu_source_value_ff     <= i_alu_source_value;
                o_shifted_source_value_ff <= i_shifted_source_value;
                o_mem_srcdest_value_ff    <= i_mem_srcdest_value;
                o_shift_carry_ff          <= i_shift_carry;
        end
end

////////////////////////////////////////////////////////////////////////////
// Checks.
////////////////////////////////////////////////////////////////////////////

// A clear that wins its cycle kills the next instruction.
a_clear_kills: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_clear_from_writeback || (i_clear_from_alu && !i_data_stall))
        |=> (o_condition_code_ff == CC_NV)
) else $error("clear did not kill the instruction");

// Stall without writeback clear freezes the stage.
a_stall_holds: assert property (
        @(posedge i_clk) disable iff (i_reset)
        (i_data_stall && !i_clear_from_writeback)
        |=> $stable({o_condition_code_ff, o_destination_index_ff, o_alu_operation_ff,
                     o_flag_update_ff, o_pc_plus_8_ff, o_alu_source_value_ff,
                     o_shifted_source_value_ff, o_mem_srcdest_value_ff,
                     o_shift_carry_ff})
) else $error("stage outputs changed during a stall");

endmodule

// ==== shift_stage.sv ====
`timescale 1ns/1ns

module shift_stage import shift_pkg::*;
#(
        parameter int PHY_REGS = 46,
        parameter int ALU_OPS  = 32,
        localparam int IDX_W   = $clog2(PHY_REGS),
        localparam int OP_W    = $clog2(ALU_OPS)
)
(
        input  logic              i_clk,
        input  logic              i_reset,

        // Pipeline control, highest priority first.
        input  logic              i_clear_from_writeback,
        input  logic              i_data_stall,
        input  logic              i_clear_from_alu,

        // From issue.
        input  logic [CC_W-1:0]   i_condition_code_ff,
        input  logic [IDX_W-1:0]  i_destination_index_ff,
        input  logic [OP_W-1:0]   i_alu_operation_ff,
        input  logic              i_flag_update_ff,
        input  logic [SRC_W-1:0]  i_alu_source_ff,
        input  logic [SRC_W-1:0]  i_shift_source_ff,
        input  logic [IDX_W-1:0]  i_mem_srcdest_index_ff,
        input  logic [WORD_W-1:0] i_alu_source_value_ff,
        input  logic [WORD_W-1:0] i_shift_source_value_ff,
        input  logic [WORD_W-1:0] i_mem_srcdest_value_ff,
        input  logic [WORD_W-1:0] i_shift_length_value_ff,
        input  shift_op_t         i_shift_operation_ff,
        input  logic              i_disable_shifter_ff,
        input  logic [WORD_W-1:0] i_pc_plus_8_ff,
        input  logic              i_force32align_ff,

        // From the ALU.
        input  logic [WORD_W-1:0] i_alu_value_nxt,
        input  logic              i_alu_dav_nxt,
        input  logic              i_carry_ff,
        input  logic              i_carry_nxt,

        // To the ALU.
        output logic [CC_W-1:0]   o_condition_code_ff,
        output logic [IDX_W-1:0]  o_destination_index_ff,
        output logic [OP_W-1:0]   o_alu_operation_ff,
        output logic              o_flag_update_ff,
        output logic [WORD_W-1:0] o_pc_plus_8_ff,
        output logic [WORD_W-1:0] o_alu_source_value_ff,
        output logic [WORD_W-1:0] o_shifted_source_value_ff,
        output logic [WORD_W-1:0] o_mem_srcdest_value_ff,
        output logic              o_shift_carry_ff
);

////////////////////////////////////////////////////////////////////////////
// Operand resolution.
////////////////////////////////////////////////////////////////////////////

logic [SRC_W-1:0]  mem_srcdest_src;
logic [WORD_W-1:0] alu_source_value;
logic [WORD_W-1:0] shift_source_value;
logic [WORD_W-1:0] mem_srcdest_value;

// Store data is always a register.
assign mem_srcdest_src = {{(SRC_W-IDX_W){1'b0}}, i_mem_srcdest_index_ff};

operand_resolver #(.PHY_REGS(PHY_REGS)) u_alu_source_resolver
(
        .i_index(i_alu_source_ff),                .i_value(i_alu_source_value_ff),
        .i_stage_dest_index(o_destination_index_ff),
        .i_alu_value(i_alu_value_nxt),            .i_alu_valid(i_alu_dav_nxt),
        .i_pc_plus_8(i_pc_plus_8_ff),             .i_align32(i_force32align_ff),
        .o_value(alu_source_value)
);

operand_resolver #(.PHY_REGS(PHY_REGS)) u_shift_source_resolver
(
        .i_index(i_shift_source_ff),              .i_value(i_shift_source_value_ff),
        .i_stage_dest_index(o_destination_index_ff),
        .i_alu_value(i_alu_value_nxt),            .i_alu_valid(i_alu_dav_nxt),
        .i_pc_plus_8(i_pc_plus_8_ff),             .i_align32(i_force32align_ff),
        .o_value(shift_source_value)
);

operand_resolver #(.PHY_REGS(PHY_REGS)) u_mem_srcdest_resolver
(
        .i_index(mem_srcdest_src),                .i_value(i_mem_srcdest_value_ff),
        .i_stage_dest_index(o_destination_index_ff),
        .i_alu_value(i_alu_value_nxt),            .i_alu_valid(i_alu_dav_nxt),
        .i_pc_plus_8(i_pc_plus_8_ff),             .i_align32(i_force32align_ff),
        .o_value(mem_srcdest_value)
);

////////////////////////////////////////////////////////////////////////////
// Shifter and operand select.
////////////////////////////////////////////////////////////////////////////

logic [WORD_W-1:0] shifter_result;
logic              shifter_carry;
logic [WORD_W-1:0] shifted_value;
logic              shift_carry_nxt;

barrel_shifter u_barrel_shifter
(
        .i_clk(i_clk),
        .i_check_en(!i_disable_shifter_ff && !i_reset),
        .i_source(shift_source_value),
        .i_amount(i_shift_length_value_ff[AMT_W-1:0]),
        .i_shift_type(i_shift_operation_ff),
        .i_carry(i_carry_ff),
        .o_result(shifter_result),
        .o_carry(shifter_carry)
);

// Bypassed shifter keeps the carry the ALU is producing now.
assign shifted_value   = i_disable_shifter_ff ? shift_source_value : shifter_result;
assign shift_carry_nxt = i_disable_shifter_ff ? i_carry_nxt : shifter_carry;

shift_stage_regs #(.PHY_REGS(PHY_REGS), .ALU_OPS(ALU_OPS)) u_shift_stage_regs
(
        .i_clk(i_clk),                                  .i_reset(i_reset),
        .i_clear_from_writeback(i_clear_from_writeback), .i_data_stall(i_data_stall),
        .i_clear_from_alu(i_clear_from_alu),
        .i_condition_code(i_condition_code_ff),
        .i_destination_index(i_destination_index_ff),
        .i_alu_operation(i_alu_operation_ff),
        .i_flag_update(i_flag_update_ff),
        .i_pc_plus_8(i_pc_plus_8_ff),
        .i_alu_source_value(alu_source_value),
        .i_shifted_source_value(shifted_value),
        .i_mem_srcdest_value(mem_srcdest_value),
        .i_shift_carry(shift_carry_nxt),
        .o_condition_code_ff(o_condition_code_ff),
        .o_destination_index_ff(o_destination_index_ff),
        .o_alu_operation_ff(o_alu_operation_ff),
        .o_flag_update_ff(o_flag_update_ff),
        .o_pc_plus_8_ff(o_pc_plus_8_ff),
        .o_alu_source_value_ff(o_alu_source_value_ff),
        .o_shifted_source_value_ff(o_shifted_source_value_ff),
        .o_mem_srcdest_value_ff(o_mem_srcdest_value_ff),
        .o_shift_carry_ff(o_shift_carry_ff)
);

endmodule

// ==== tb_shift_model.svh ====
`ifndef TB_SHIFT_MODEL_SVH
`define TB_SHIFT_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Reference model of the shift stage datapath.
////////////////////////////////////////////////////////////////////////////

// Shift rules by amount range. Result packed as {carry, word}.
function automatic logic [WORD_W:0] model_shift(input logic [WORD_W-1:0] src,
        input logic [AMT_W-1:0] amt, input shift_op_t op, input logic cin);
        int n;
        int k;
        n = int'(amt);
        k = n % WORD_W;
        // RRX ignores the amount entirely.
        if (op == SH_RRX)
                return {src[0], cin, src[WORD_W-1:1]};
        if (n == 0)
                return {cin, src};
        case (op)
        SH_LSL:  return (n < 32) ? {1'(src >> (WORD_W - n)), src << n}
                                 : {(n == 32) && src[0], {WORD_W{1'b0}}};
        SH_LSR:  return (n < 32) ? {1'(src >> (n - 1)), src >> n}
                                 : {(n == 32) && src[WORD_W-1], {WORD_W{1'b0}}};
        // Sign bit everywhere once the amount reaches a word.
        SH_ASR:  return (n < 32) ? {1'(src >> (n - 1)), WORD_W'($signed(src) >>> n)}
                                 : {src[WORD_W-1], {WORD_W{src[WORD_W-1]}}};
        SH_ROR:  return (k == 0) ? {src[WORD_W-1], src}
                                 : {1'(src >> (k - 1)), (src >> k) | (src << (WORD_W - k))};
        default: return {cin, src};
        endcase
endfunction

// Immediate, then PC, then forward from the ALU, then the issue read.
function automatic logic [WORD_W-1:0] model_operand(input logic [SRC_W-1:0] src,
        input logic [WORD_W-1:0] issue_value, input logic [IDX_W-1:0] last_dest,
        input logic alu_valid, input logic [WORD_W-1:0] alu_value,
        input logic [WORD_W-1:0] pc, input logic align);
        if (src[IMMED_EN])
                return src[WORD_W-1:0];
        if (src[WORD_W-1:0] == WORD_W'(PHY_PC))
                return align ? {pc[WORD_W-1:2], 2'b00} : pc;
        if ((src[WORD_W-1:0] == WORD_W'(last_dest)) && alu_valid)
                return alu_value;
        return issue_value;
endfunction

`endif

// ==== tb_shift_stage.sv ====
`timescale 1ns/1ns

module tb_shift_stage import shift_pkg::*;
();

localparam int PHY_REGS = 46;
localparam int ALU_OPS  = 32;
localparam int IDX_W    = $clog2(PHY_REGS);
localparam int OP_W     = $clog2(ALU_OPS);
localparam int CLK_NS   = 8;

// Cycles per test.
localparam int RESET_CYCLES = 4;
localparam int N_RESOLVE    = 48;
localparam int N_FORWARD    = 64;
localparam int N_SHIFT      = 320;
localparam int N_BYPASS     = 32;
localparam int N_CONTROL    = 120;

// One closing cycle per test, plus some slack.
localparam int TOTAL_CYCLES = RESET_CYCLES + N_RESOLVE + N_FORWARD + N_SHIFT + N_BYPASS
                              + N_CONTROL + 6;
localparam int WATCHDOG_NS  = TOTAL_CYCLES * CLK_NS + 200;

logic              i_clk, i_reset, i_clear_from_writeback, i_data_stall, i_clear_from_alu;
logic [CC_W-1:0]   i_condition_code_ff, o_condition_code_ff;
logic [IDX_W-1:0]  i_destination_index_ff, i_mem_srcdest_index_ff, o_destination_index_ff;
logic [OP_W-1:0]   i_alu_operation_ff, o_alu_operation_ff;
logic [SRC_W-1:0]  i_alu_source_ff, i_shift_source_ff;
logic [WORD_W-1:0] i_alu_source_value_ff, i_shift_source_value_ff, i_mem_srcdest_value_ff;
logic [WORD_W-1:0] i_shift_length_value_ff, i_pc_plus_8_ff, i_alu_value_nxt;
logic              i_flag_update_ff, i_disable_shifter_ff, i_force32align_ff;
logic              i_alu_dav_nxt, i_carry_ff, i_carry_nxt, o_flag_update_ff, o_shift_carry_ff;
shift_op_t         i_shift_operation_ff;
logic [WORD_W-1:0] o_pc_plus_8_ff, o_alu_source_value_ff, o_shifted_source_value_ff;
logic [WORD_W-1:0] o_mem_srcdest_value_ff;

// Expected values for the cycle being driven.
logic [IDX_W-1:0]  model_dest;
logic [WORD_W-1:0] exp_alu_source, exp_shift_source, exp_mem_srcdest, exp_shifted;
logic [WORD_W:0]   exp_shift;
logic              exp_carry, load_cycle;
logic [IDX_W+OP_W+4*WORD_W+1:0] held_fields;
int                fail_count, fails_at_start, tests_passed, tests_failed;

`include "tb_shift_model.svh"

shift_stage #(.PHY_REGS(PHY_REGS), .ALU_OPS(ALU_OPS)) i_shift_stage (.*);

always #(CLK_NS / 2) i_clk = !i_clk;

////////////////////////////////////////////////////////////////////////////
// Reference side.
////////////////////////////////////////////////////////////////////////////

assign load_cycle = !i_reset && !i_clear_from_writeback && !i_data_stall && !i_clear_from_alu;
assign exp_alu_source = model_operand(i_alu_source_ff, i_alu_source_value_ff, model_dest,
        i_alu_dav_nxt, i_alu_value_nxt, i_pc_plus_8_ff, i_force32align_ff);
assign exp_shift_source = model_operand(i_shift_source_ff, i_shift_source_value_ff, model_dest,
        i_alu_dav_nxt, i_alu_value_nxt, i_pc_plus_8_ff, i_force32align_ff);
assign exp_mem_srcdest = model_operand(SRC_W'(i_mem_srcdest_index_ff), i_mem_srcdest_value_ff,
        model_dest, i_alu_dav_nxt, i_alu_value_nxt, i_pc_plus_8_ff, i_force32align_ff);
assign exp_shift = model_shift(exp_shift_source, i_shift_length_value_ff[AMT_W-1:0],
        i_shift_operation_ff, i_carry_ff);
// Bypass keeps the resolved source and the carry in flight.
assign exp_shifted = i_disable_shifter_ff ? exp_shift_source : exp_shift[WORD_W-1:0];
assign exp_carry   = i_disable_shifter_ff ? i_carry_nxt : exp_shift[WORD_W];
// Everything a clear must leave alone.
assign held_fields = {o_destination_index_ff, o_alu_operation_ff, o_flag_update_ff,
        o_pc_plus_8_ff, o_alu_source_value_ff, o_shifted_source_value_ff,
        o_mem_srcdest_value_ff, o_shift_carry_ff};

// Destination copy, loaded only when a whole instruction enters the stage.
always @(posedge i_clk)
begin
        if (i_reset)
                model_dest <= '0;
        else if (load_cycle)
                model_dest <= i_destination_index_ff;
end

////////////////////////////////////////////////////////////////////////////
// Checks.
////////////////////////////////////////////////////////////////////////////

function automatic void report_fail(input string what);
        fail_count++;
        $display("FAIL %0t: %s", $time, what);
endfunction

a_reset_state: assert property (@(posedge i_clk) i_reset |=> (o_condition_code_ff == CC_NV)
        && !o_shift_carry_ff && (held_fields == '0)) else report_fail("reset state wrong");
a_load_fields: assert property (@(posedge i_clk) load_cycle |=>
        (o_condition_code_ff == $past(i_condition_code_ff))
        && (o_destination_index_ff == $past(i_destination_index_ff))
        && (o_alu_operation_ff == $past(i_alu_operation_ff))
        && (o_flag_update_ff == $past(i_flag_update_ff))
        && (o_pc_plus_8_ff == $past(i_pc_plus_8_ff))) else report_fail("fields not loaded");
a_alu_source: assert property (@(posedge i_clk) load_cycle |=>
        o_alu_source_value_ff == $past(exp_alu_source)) else report_fail("ALU source value");
a_mem_srcdest: assert property (@(posedge i_clk) load_cycle |=>
        o_mem_srcdest_value_ff == $past(exp_mem_srcdest)) else report_fail("store data value");
a_shifted: assert property (@(posedge i_clk) load_cycle |=>
        o_shifted_source_value_ff == $past(exp_shifted)) else report_fail("shifted value");
a_shift_carry: assert property (@(posedge i_clk) load_cycle |=>
        o_shift_carry_ff == $past(exp_carry)) else report_fail("shifter carry");
a_writeback_clear: assert property (@(posedge i_clk) !i_reset && i_clear_from_writeback |=>
        (o_condition_code_ff == CC_NV) && $stable(held_fields))
        else report_fail("writeback clear");
a_stall_holds: assert property (@(posedge i_clk)
        !i_reset && !i_clear_from_writeback && i_data_stall |=>
        $stable(o_condition_code_ff) && $stable(held_fields))
        else report_fail("stall did not hold");
a_alu_clear: assert property (@(posedge i_clk)
        !i_reset && !i_clear_from_writeback && !i_data_stall && i_clear_from_alu |=>
        (o_condition_code_ff == CC_NV) && $stable(held_fields)) else report_fail("ALU clear");

////////////////////////////////////////////////////////////////////////////
// Stimulus.
////////////////////////////////////////////////////////////////////////////

// Immediate, PC or a plain register, about a third each.
function automatic logic [SRC_W-1:0] random_source();
        case ($urandom_range(0, 2))
        0:       return {1'b1, $urandom};
        1:       return SRC_W'(PHY_PC);
        default: return SRC_W'($urandom_range(0, PHY_REGS - 1));
        endcase
endfunction

// New instruction on every input. Controls idle.
task automatic drive_random();
        i_condition_code_ff     = CC_W'($urandom_range(0, 14));
        i_destination_index_ff  = IDX_W'($urandom_range(0, PHY_REGS - 1));
        i_alu_operation_ff      = OP_W'($urandom_range(0, ALU_OPS - 1));
        i_flag_update_ff        = 1'($urandom);
        i_alu_source_ff         = random_source();
        i_shift_source_ff       = random_source();
        i_mem_srcdest_index_ff  = IDX_W'($urandom_range(0, PHY_REGS - 1));
        i_alu_source_value_ff   = $urandom;
        i_shift_source_value_ff = $urandom;
        i_mem_srcdest_value_ff  = $urandom;
        i_shift_length_value_ff = $urandom;
        i_shift_operation_ff    = shift_op_t'($urandom_range(0, 4));
        i_disable_shifter_ff    = 1'($urandom);
        i_pc_plus_8_ff          = $urandom;
        i_force32align_ff       = 1'($urandom);
        i_alu_value_nxt         = $urandom;
        i_alu_dav_nxt           = 1'($urandom);
        i_carry_ff              = 1'($urandom);
        i_carry_nxt             = 1'($urandom);
        i_clear_from_writeback  = 1'b0;
        i_data_stall            = 1'b0;
        i_clear_from_alu        = 1'b0;
endtask

// Inputs change just after the edge.
task automatic next_cycle();
        @(posedge i_clk);
        #1;
endtask

// One more edge lets the last check of the test fire.
task automatic end_test(input string name);
        next_cycle();
        if (fail_count == fails_at_start)
        begin
                tests_passed++;
                $display("test %s: ok", name);
        end
        else
        begin
                tests_failed++;
                $display("test %s: %0d failed checks", name, fail_count - fails_at_start);
        end
        fails_at_start = fail_count;
endtask

initial
begin
        void'($urandom(32'ha905));
        fail_count     = 0;
        fails_at_start = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        i_clk          = 1'b0;
        i_reset        = 1'b1;
        drive_random();
        repeat (RESET_CYCLES) next_cycle();
        i_reset = 1'b0;
        end_test("reset state");

        // Immediate ALU source, PC shift source and PC store data.
        repeat (N_RESOLVE)
        begin
                drive_random();
                i_alu_dav_nxt          = 1'b0;
                i_alu_source_ff        = {1'b1, $urandom};
                i_shift_source_ff      = SRC_W'(PHY_PC);
                i_mem_srcdest_index_ff = IDX_W'(PHY_PC);
                i_disable_shifter_ff   = 1'b1;
                next_cycle();
        end
        end_test("resolver sources");

        // Operands aim at the instruction ahead. Store data hits half the time.
        repeat (N_FORWARD)
        begin
                drive_random();
                i_alu_source_ff   = SRC_W'(model_dest);
                i_shift_source_ff = SRC_W'(model_dest);
                if ($urandom_range(0, 1) == 0)
                        i_mem_srcdest_index_ff = model_dest;
                next_cycle();
        end
        end_test("forwarding");

        // Amounts lean on 0, 1, 32, 33 and other multiples of 32.
        repeat (N_SHIFT)
        begin
                drive_random();
                i_disable_shifter_ff = 1'b0;
                i_shift_length_value_ff[AMT_W-1:0] = AMT_W'(($urandom_range(0, 1) == 0)
                        ? 32 * $urandom_range(0, 7) + $urandom_range(0, 1)
                        : $urandom_range(0, 255));
                next_cycle();
        end
        end_test("shifter");

        repeat (N_BYPASS)
        begin
                drive_random();
                i_disable_shifter_ff = 1'b1;
                next_cycle();
        end
        end_test("shifter disabled");

        // Controls overlap often enough to reach every priority case.
        repeat (N_CONTROL)
        begin
                drive_random();
                i_clear_from_writeback = ($urandom_range(0, 4) == 0);
                i_data_stall           = ($urandom_range(0, 2) == 0);
                i_clear_from_alu       = ($urandom_range(0, 3) == 0);
                next_cycle();
        end
        end_test("pipeline control");

        $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
        if (fail_count == 0)
                $display("ALL CHECKS PASSED");
        else
                $display("CHECKS FAILED");
        $finish;
end

// Watchdog.
initial
begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("CHECKS FAILED");
        $finish;
end

endmodule

// ==== compile.f ====
+incdir+.
shift_pkg.sv
operand_resolver.sv
barrel_shifter.sv
shift_stage_regs.sv
shift_stage.sv
tb_shift_stage.sv

// ==== Makefile ====
SRCS := shift_pkg.sv operand_resolver.sv barrel_shifter.sv shift_stage_regs.sv \
        shift_stage.sv tb_shift_stage.sv tb_shift_model.svh compile.f

.PHONY: run clean

run: obj_dir/Vtb_shift_stage
	@out="$$(./obj_dir/Vtb_shift_stage)"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

obj_dir/Vtb_shift_stage: $(SRCS)
	verilator --binary --assert --timescale 1ns/1ns --top-module tb_shift_stage -f compile.f

clean:
	rm -rf obj_dir
